/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -sv -j 0 --top-module tb_axi_mux -f compile.f

run: compile
	./obj_dir/Vtb_axi_mux | tee /dev/stderr | grep -q "Finished with no errors"

clean:
	rm -rf obj_dir

/* compile.f */
hdl/axi_mux_pkg.sv
hdl/aw_arbiter.sv
hdl/w_order_fifo.sv
hdl/w_switch.sv
hdl/b_response_router.sv
hdl/axi_mux.sv
sim/axi_mux_sva.sv
sim/tb_axi_mux.sv

/* hdl/aw_arbiter.sv */
`timescale 1ns/1ps
// AW arbiter of the write mux
// Round-robin grant with lock-in, ID prefix and a single FIFO push per AW
module aw_arbiter import axi_mux_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  // Slave AW channels
  input  logic      slv_aw_valid_i [NUM_PORTS],
  output logic      slv_aw_ready_o [NUM_PORTS],
  input  slv_id_t   slv_aw_id_i    [NUM_PORTS],
  input  addr_t     slv_aw_addr_i  [NUM_PORTS],
  input  len_t      slv_aw_len_i   [NUM_PORTS],
  // Master AW channel
  output logic      mst_aw_valid_o,
  input  logic      mst_aw_ready_i,
  output mst_id_t   mst_aw_id_o,
  output addr_t     mst_aw_addr_o,
  output len_t      mst_aw_len_o,
  // W order FIFO
  output logic      fifo_push_o,
  output port_idx_t fifo_idx_o,
  input  logic      fifo_full_i
);

  aw_state_e state_q, state_d;
  port_idx_t rr_ptr_q, rr_ptr_d;      // Port with the highest priority
  port_idx_t lock_idx_q, lock_idx_d;  // Winner held during a master stall
  port_idx_t sel_idx;                 // Round-robin pick of this cycle
  port_idx_t grant_idx;               // Port that drives the master AW
  logic      any_req;
  logic      aw_xfer;

  // Next port in round-robin order
  function automatic port_idx_t next_port(port_idx_t idx);
    return (int'(idx) == NUM_PORTS - 1) ? '0 : idx + 1'b1;
  endfunction

  // ------------------------------------------------------------------------
  // Round-robin pick, starting at the pointer
  // ------------------------------------------------------------------------
  always_comb begin
    int unsigned cand;
    any_req = 1'b0;
    sel_idx = rr_ptr_q;
    for (int unsigned i = 0; i < NUM_PORTS; i++) begin
      cand = (int'(rr_ptr_q) + i) % NUM_PORTS;
      if (!any_req && slv_aw_valid_i[cand]) begin
        any_req = 1'b1;
        sel_idx = port_idx_t'(cand);
      end
    end
  end

  // ------------------------------------------------------------------------
  // Issue control
  // ------------------------------------------------------------------------
  always_comb begin
    state_d        = state_q;
    rr_ptr_d       = rr_ptr_q;
    lock_idx_d     = lock_idx_q;
    grant_idx      = sel_idx;
    mst_aw_valid_o = 1'b0;
    fifo_push_o    = 1'b0;
    case (state_q)
      AW_IDLE: begin
        // No issue while the FIFO cannot take the index
        if (any_req && !fifo_full_i) begin
          mst_aw_valid_o = 1'b1;
          fifo_push_o    = 1'b1;
          if (mst_aw_ready_i) begin
            rr_ptr_d = next_port(sel_idx);
          end else begin
            state_d    = AW_LOCKED;
            lock_idx_d = sel_idx;
          end
        end
      end
      AW_LOCKED: begin
        grant_idx      = lock_idx_q;   // Lock-in until the transfer
        mst_aw_valid_o = 1'b1;
        if (mst_aw_ready_i) begin
          rr_ptr_d = next_port(lock_idx_q);
          state_d  = AW_IDLE;
        end
      end
      default: state_d = AW_IDLE;
    endcase
  end

  assign aw_xfer = mst_aw_valid_o && mst_aw_ready_i;

  // Ready only to the granted port, on the transfer
  always_comb begin
    for (int unsigned i = 0; i < NUM_PORTS; i++) begin
      slv_aw_ready_o[i] = aw_xfer && (grant_idx == port_idx_t'(i));
    end
  end

  assign mst_aw_id_o   = {grant_idx, slv_aw_id_i[grant_idx]};  // Port index prefix
  assign mst_aw_addr_o = slv_aw_addr_i[grant_idx];
  assign mst_aw_len_o  = slv_aw_len_i[grant_idx];
  assign fifo_idx_o    = grant_idx;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= AW_IDLE;
      rr_ptr_q   <= '0;
      lock_idx_q <= '0;
    end else begin
      state_q    <= state_d;
      rr_ptr_q   <= rr_ptr_d;
      lock_idx_q <= lock_idx_d;
    end
  end

endmodule

/* hdl/axi_mux.sv */
`timescale 1ns/1ps
// AXI4 write-path mux, four slave ports onto one master port
// AW arbitration with ID prefix, W ordering by grant and B routing by prefix
module axi_mux import axi_mux_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_n_i,
  // Slave AW channels
  input  logic    slv_aw_valid_i [NUM_PORTS],
  output logic    slv_aw_ready_o [NUM_PORTS],
  input  slv_id_t slv_aw_id_i    [NUM_PORTS],
  input  addr_t   slv_aw_addr_i  [NUM_PORTS],
  input  len_t    slv_aw_len_i   [NUM_PORTS],
  // Slave W channels
  input  logic    slv_w_valid_i  [NUM_PORTS],
  output logic    slv_w_ready_o  [NUM_PORTS],
  input  data_t   slv_w_data_i   [NUM_PORTS],
  input  strb_t   slv_w_strb_i   [NUM_PORTS],
  input  logic    slv_w_last_i   [NUM_PORTS],
  // Slave B channels
  output logic    slv_b_valid_o  [NUM_PORTS],
  input  logic    slv_b_ready_i  [NUM_PORTS],
  output slv_id_t slv_b_id_o     [NUM_PORTS],
  output resp_t   slv_b_resp_o   [NUM_PORTS],
  // Master AW channel
  output logic    mst_aw_valid_o,
  input  logic    mst_aw_ready_i,
  output mst_id_t mst_aw_id_o,
  output addr_t   mst_aw_addr_o,
  output len_t    mst_aw_len_o,
  // Master W channel
  output logic    mst_w_valid_o,
  input  logic    mst_w_ready_i,
  output data_t   mst_w_data_o,
  output strb_t   mst_w_strb_o,
  output logic    mst_w_last_o,
  // Master B channel
  input  logic    mst_b_valid_i,
  output logic    mst_b_ready_o,
  input  mst_id_t mst_b_id_i,
  input  resp_t   mst_b_resp_i
);

  // W order FIFO links
  logic      fifo_push;
  port_idx_t fifo_idx;
  logic      fifo_full;
  logic      fifo_empty;
  port_idx_t fifo_head;
  logic      fifo_pop;

  // ------------------------------------------------------------------------
  // AW channel
  // ------------------------------------------------------------------------
  aw_arbiter i_aw_arbiter (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .slv_aw_valid_i ( slv_aw_valid_i ),
    .slv_aw_ready_o ( slv_aw_ready_o ),
    .slv_aw_id_i    ( slv_aw_id_i    ),
    .slv_aw_addr_i  ( slv_aw_addr_i  ),
    .slv_aw_len_i   ( slv_aw_len_i   ),
    .mst_aw_valid_o ( mst_aw_valid_o ),
    .mst_aw_ready_i ( mst_aw_ready_i ),
    .mst_aw_id_o    ( mst_aw_id_o    ),
    .mst_aw_addr_o  ( mst_aw_addr_o  ),
    .mst_aw_len_o   ( mst_aw_len_o   ),
    .fifo_push_o    ( fifo_push      ),
    .fifo_idx_o     ( fifo_idx       ),
    .fifo_full_i    ( fifo_full      )
  );

  w_order_fifo i_w_order_fifo (
    .clk_i   ( clk_i      ),
    .rst_n_i ( rst_n_i    ),
    .push_i  ( fifo_push  ),
    .idx_i   ( fifo_idx   ),
    .pop_i   ( fifo_pop   ),
    .head_o  ( fifo_head  ),
    .empty_o ( fifo_empty ),
    .full_o  ( fifo_full  )
  );

  // ------------------------------------------------------------------------
  // W channel
  // ------------------------------------------------------------------------
  w_switch i_w_switch (
    .slv_w_valid_i ( slv_w_valid_i ),
    .slv_w_ready_o ( slv_w_ready_o ),
    .slv_w_data_i  ( slv_w_data_i  ),
    .slv_w_strb_i  ( slv_w_strb_i  ),
    .slv_w_last_i  ( slv_w_last_i  ),
    .mst_w_valid_o ( mst_w_valid_o ),
    .mst_w_ready_i ( mst_w_ready_i ),
    .mst_w_data_o  ( mst_w_data_o  ),
    .mst_w_strb_o  ( mst_w_strb_o  ),
    .mst_w_last_o  ( mst_w_last_o  ),
    .head_i        ( fifo_head     ),
    .empty_i       ( fifo_empty    ),
    .pop_o         ( fifo_pop      )
  );

  // ------------------------------------------------------------------------
  // B channel
  // ------------------------------------------------------------------------
  b_response_router i_b_response_router (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .mst_b_valid_i ( mst_b_valid_i ),
    .mst_b_ready_o ( mst_b_ready_o ),
    .mst_b_id_i    ( mst_b_id_i    ),
    .mst_b_resp_i  ( mst_b_resp_i  ),
    .slv_b_valid_o ( slv_b_valid_o ),
    .slv_b_ready_i ( slv_b_ready_i ),
    .slv_b_id_o    ( slv_b_id_o    ),
    .slv_b_resp_o  ( slv_b_resp_o  )
  );

endmodule

/* hdl/axi_mux_pkg.sv */
// AXI4 write-path mux package
// Port count, channel widths, vector types and the AW lock state encoding
package axi_mux_pkg;

  // ------------------------------------------------------------------------
  // Counts and widths
  // ------------------------------------------------------------------------
  localparam int unsigned NUM_PORTS   = 4;
  localparam int unsigned PORT_IDX_W  = $clog2(NUM_PORTS);   // ID prefix width
  localparam int unsigned SLV_ID_W    = 4;
  localparam int unsigned MST_ID_W    = SLV_ID_W + PORT_IDX_W;
  localparam int unsigned ADDR_W      = 32;
  localparam int unsigned DATA_W      = 32;
  localparam int unsigned STRB_W      = DATA_W / 8;
  localparam int unsigned LEN_W       = 8;                   // AXI4 burst length
  localparam int unsigned RESP_W      = 2;

  // Outstanding writes whose W bursts are still pending
  localparam int unsigned MAX_W_TRANS = 8;
  localparam int unsigned FIFO_PTR_W  = $clog2(MAX_W_TRANS);
  localparam int unsigned FIFO_CNT_W  = $clog2(MAX_W_TRANS + 1);

  // ------------------------------------------------------------------------
  // Channel field types
  // ------------------------------------------------------------------------
  typedef logic [PORT_IDX_W-1:0] port_idx_t;
  typedef logic [SLV_ID_W-1:0]   slv_id_t;
  typedef logic [MST_ID_W-1:0]   mst_id_t;  // {port index, slave ID}
  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [LEN_W-1:0]      len_t;     // Beats minus one
  typedef logic [DATA_W-1:0]     data_t;
  typedef logic [STRB_W-1:0]     strb_t;
  typedef logic [RESP_W-1:0]     resp_t;

  // AW issue lock
  typedef enum logic {
    AW_IDLE,    // Free to arbitrate
    AW_LOCKED   // Granted AW stalled by the master, already pushed
  } aw_state_e;

endpackage

/* hdl/b_response_router.sv */
`timescale 1ns/1ps
// B response router
// One-entry register stage that steers master B responses by their ID prefix
module b_response_router import axi_mux_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_n_i,
  // Master B channel
  input  logic    mst_b_valid_i,
  output logic    mst_b_ready_o,
  input  mst_id_t mst_b_id_i,
  input  resp_t   mst_b_resp_i,
  // Slave B channels
  output logic    slv_b_valid_o [NUM_PORTS],
  input  logic    slv_b_ready_i [NUM_PORTS],
  output slv_id_t slv_b_id_o    [NUM_PORTS],
  output resp_t   slv_b_resp_o  [NUM_PORTS]
);

  logic      full_q;
  mst_id_t   id_q;
  resp_t     resp_q;
  port_idx_t b_port;    // Owner of the held response
  logic      drain;
  logic      capture;

  assign b_port        = id_q[MST_ID_W-1 -: PORT_IDX_W];
  assign drain         = full_q && slv_b_ready_i[b_port];
  assign mst_b_ready_o = !full_q || drain;   // Accept while empty or draining
  assign capture       = mst_b_valid_i && mst_b_ready_o;

  always_comb begin
    for (int unsigned i = 0; i < NUM_PORTS; i++) begin
      slv_b_valid_o[i] = full_q && (b_port == port_idx_t'(i));
      slv_b_id_o[i]    = id_q[SLV_ID_W-1:0];   // Prefix stripped
      slv_b_resp_o[i]  = resp_q;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      full_q <= 1'b0;
    end else if (capture) begin
      full_q <= 1'b1;
    end else if (drain) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture) begin
      id_q   <= mst_b_id_i;
      resp_q <= mst_b_resp_i;
    end
  end

endmodule

/* hdl/w_order_fifo.sv */
`timescale 1ns/1ps
// W order FIFO
// Holds the port indices of granted writes in AW grant order
module w_order_fifo import axi_mux_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      push_i,
  input  port_idx_t idx_i,
  input  logic      pop_i,
  output port_idx_t head_o,
  output logic      empty_o,
  output logic      full_o
);

  port_idx_t              mem [MAX_W_TRANS];
  logic [FIFO_PTR_W-1:0]  wr_ptr_q;
  logic [FIFO_PTR_W-1:0]  rd_ptr_q;
  logic [FIFO_CNT_W-1:0]  count_q;
  logic                   push_ok;
  logic                   pop_ok;

  // Wrapping pointer increment
  function automatic logic [FIFO_PTR_W-1:0] ptr_inc(logic [FIFO_PTR_W-1:0] ptr);
    return (ptr == FIFO_PTR_W'(MAX_W_TRANS - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == FIFO_CNT_W'(MAX_W_TRANS));
  assign push_ok = push_i && !full_o;
  assign pop_ok  = pop_i && !empty_o;
  assign head_o  = mem[rd_ptr_q];   // Registered head, no fall-through

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_ok) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop_ok)  rd_ptr_q <= ptr_inc(rd_ptr_q);
      case ({push_ok, pop_ok})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;   // Idle, or push and pop together
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      mem[wr_ptr_q] <= idx_i;
    end
  end

endmodule

/* hdl/w_switch.sv */
`timescale 1ns/1ps
// W channel switch
// Routes the W beats of the FIFO head port to the master and pops on last
module w_switch import axi_mux_pkg::*; (
  // Slave W channels
  input  logic      slv_w_valid_i [NUM_PORTS],
  output logic      slv_w_ready_o [NUM_PORTS],
  input  data_t     slv_w_data_i  [NUM_PORTS],
  input  strb_t     slv_w_strb_i  [NUM_PORTS],
  input  logic      slv_w_last_i  [NUM_PORTS],
  // Master W channel
  output logic      mst_w_valid_o,
  input  logic      mst_w_ready_i,
  output data_t     mst_w_data_o,
  output strb_t     mst_w_strb_o,
  output logic      mst_w_last_o,
  // W order FIFO
  input  port_idx_t head_i,
  input  logic      empty_i,
  output logic      pop_o
);

  logic head_valid;

  assign head_valid    = !empty_i && slv_w_valid_i[head_i];
  assign mst_w_valid_o = head_valid;

  // Only the head port sees the master ready
  always_comb begin
    for (int unsigned i = 0; i < NUM_PORTS; i++) begin
      slv_w_ready_o[i] = !empty_i && mst_w_ready_i && (head_i == port_idx_t'(i));
    end
  end

  // Payload follows the head
  assign mst_w_data_o = slv_w_data_i[head_i];
  assign mst_w_strb_o = slv_w_strb_i[head_i];
  assign mst_w_last_o = slv_w_last_i[head_i];

  // Burst done on the last beat transfer
  assign pop_o = head_valid && mst_w_ready_i && slv_w_last_i[head_i];

endmodule

/* sim/axi_mux_stim.txt */
// One write per line, hex columns: port, slave ID, address, length (beats-1), data seed
// Response code returned by the master model is address bits [1:0]
0 1 00001000 03 00000100
1 2 00002001 00 00000200
2 3 00003002 07 00000300
3 4 00004003 02 00000400
0 5 00001011 01 00000500
1 6 00002012 05 00000600
2 7 00003013 00 00000700
3 8 00004010 06 00000800
0 9 00001022 02 00000900
1 a 00002023 03 00000a00
2 b 00003020 01 00000b00
3 c 00004021 04 00000c00
0 d 00001033 00 00000d00
1 e 00002030 07 00000e00
2 f 00003031 02 00000f00
3 0 00004032 01 00001000
0 2 00001040 05 00001100
1 4 00002041 01 00001200
2 6 00003042 03 00001300
3 8 00004043 00 00001400
0 a 00001051 06 00001500
1 c 00002052 02 00001600
2 e 00003053 04 00001700
3 1 00004050 03 00001800

/* sim/axi_mux_sva.sv */
`timescale 1ns/1ps
// Handshake assertions bound into the write-path mux
module axi_mux_sva import axi_mux_pkg::*; (
  input logic    clk_i,
  input logic    rst_n_i,
  input logic    mst_aw_valid_o,
  input logic    mst_aw_ready_i,
  input mst_id_t mst_aw_id_o,
  input addr_t   mst_aw_addr_o,
  input len_t    mst_aw_len_o,
  input logic    mst_w_valid_o,
  input logic    mst_w_ready_i,
  input data_t   mst_w_data_o,
  input logic    mst_w_last_o,
  input logic    slv_b_valid_o [NUM_PORTS],
  input logic    slv_w_ready_o [NUM_PORTS],
  input logic    fifo_empty
);

  aw_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mst_aw_valid_o && !mst_aw_ready_i |=> mst_aw_valid_o && $stable(mst_aw_id_o)
      && $stable(mst_aw_addr_o) && $stable(mst_aw_len_o))
    else $error("Master AW changed while stalled");

  w_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mst_w_valid_o && !mst_w_ready_i |=> mst_w_valid_o && $stable(mst_w_data_o)
      && $stable(mst_w_last_o))
    else $error("Master W changed while stalled");

  b_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0({slv_b_valid_o[3], slv_b_valid_o[2], slv_b_valid_o[1], slv_b_valid_o[0]}))
    else $error("More than one slave B valid");

  w_ready_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    fifo_empty |-> !(slv_w_ready_o[0] || slv_w_ready_o[1] || slv_w_ready_o[2]
      || slv_w_ready_o[3]))
    else $error("Slave W ready with an empty order FIFO");

endmodule

bind axi_mux axi_mux_sva i_axi_mux_sva (
  .clk_i(clk_i), .rst_n_i(rst_n_i),
  .mst_aw_valid_o(mst_aw_valid_o), .mst_aw_ready_i(mst_aw_ready_i),
  .mst_aw_id_o(mst_aw_id_o), .mst_aw_addr_o(mst_aw_addr_o), .mst_aw_len_o(mst_aw_len_o),
  .mst_w_valid_o(mst_w_valid_o), .mst_w_ready_i(mst_w_ready_i),
  .mst_w_data_o(mst_w_data_o), .mst_w_last_o(mst_w_last_o),
  .slv_b_valid_o(slv_b_valid_o), .slv_w_ready_o(slv_w_ready_o),
  .fifo_empty(fifo_empty)
);

/* sim/tb_axi_mux.sv */
`timescale 1ns/1ps
// Testbench for the AXI4 write-path mux
// File-driven slave ports, a master-side memory model and scoreboard checks
module tb_axi_mux import axi_mux_pkg::*; ();

  localparam int NUM_TRANS = 24;
  localparam int TIMEOUT   = 4000;   // Cycles per wait

  logic    clk_i = 1'b0;
  logic    rst_n_i = 1'b0;
  logic    slv_aw_valid_i [NUM_PORTS];
  logic    slv_aw_ready_o [NUM_PORTS];
  slv_id_t slv_aw_id_i    [NUM_PORTS];
  addr_t   slv_aw_addr_i  [NUM_PORTS];
  len_t    slv_aw_len_i   [NUM_PORTS];
  logic    slv_w_valid_i  [NUM_PORTS];
  logic    slv_w_ready_o  [NUM_PORTS];
  data_t   slv_w_data_i   [NUM_PORTS];
  strb_t   slv_w_strb_i   [NUM_PORTS];
  logic    slv_w_last_i   [NUM_PORTS];
  logic    slv_b_valid_o  [NUM_PORTS];
  logic    slv_b_ready_i  [NUM_PORTS];
  slv_id_t slv_b_id_o     [NUM_PORTS];
  resp_t   slv_b_resp_o   [NUM_PORTS];
  logic    mst_aw_valid_o, mst_aw_ready_i;
  mst_id_t mst_aw_id_o;
  addr_t   mst_aw_addr_o;
  len_t    mst_aw_len_o;
  logic    mst_w_valid_o, mst_w_ready_i, mst_w_last_o;
  data_t   mst_w_data_o;
  strb_t   mst_w_strb_o;
  logic    mst_b_valid_i, mst_b_ready_o;
  mst_id_t mst_b_id_i;
  resp_t   mst_b_resp_i;

  axi_mux DUT (.*);

  always #5 clk_i = ~clk_i;

  // Transaction table from the data file
  logic [31:0] stim_mem [NUM_TRANS*5];
  port_idx_t   tr_port [NUM_TRANS];
  slv_id_t     tr_id   [NUM_TRANS];
  addr_t       tr_addr [NUM_TRANS];
  len_t        tr_len  [NUM_TRANS];
  data_t       tr_seed [NUM_TRANS];
  int          port_list [NUM_PORTS][NUM_TRANS];
  int          port_cnt  [NUM_PORTS];

  // Scoreboard state
  int   aw_order [$];    // Transactions with AW done and W pending
  int   b_pending [$];   // Transactions waiting for their B
  int   aw_seen [NUM_PORTS];
  int   aw_sent [NUM_PORTS];   // AW handshakes finished by each port driver
  int   b_seen  [NUM_PORTS];
  int   wait_grants [NUM_PORTS];
  int   beat;
  int   b_done;
  int   errors;
  logic random_mode;
  logic hold_w0;
  logic b_taken;
  logic [31:0] lcg_state = 32'h7bd7;

  function automatic logic rand_bit();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[28] | lcg_state[26];   // Ready about 3 of 4 cycles
  endfunction

  task automatic check_value(input string msg, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s, got %0h expected %0h", $time, msg, got, exp);
      errors++;
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("Timeout at %0t while waiting for %s", $time, what);
    $display("Finished with errors");
    $finish;
  endtask

  // ------------------------------------------------------------------------
  // Slave port drivers
  // ------------------------------------------------------------------------
  task automatic wait_slave_ready(input int p, input logic is_w, input string what);
    int cycles;
    cycles = 0;
    forever begin
      @(negedge clk_i);
      if (is_w ? slv_w_ready_o[p] : slv_aw_ready_o[p]) break;
      cycles++;
      if (cycles > TIMEOUT) timeout_fail(what);
    end
    @(posedge clk_i);
    #1;
  endtask

  // AW requests run ahead of the W bursts
  task automatic drive_aw(input int p);
    int t;
    for (int k = 0; k < port_cnt[p]; k++) begin
      t = port_list[p][k];
      slv_aw_valid_i[p] = 1'b1;
      slv_aw_id_i[p]    = tr_id[t];
      slv_aw_addr_i[p]  = tr_addr[t];
      slv_aw_len_i[p]   = tr_len[t];
      wait_slave_ready(p, 1'b0, "slave AW ready");
      slv_aw_valid_i[p] = 1'b0;
      aw_sent[p]++;
    end
  endtask

  task automatic drive_w(input int p);
    int t;
    int cycles;
    for (int k = 0; k < port_cnt[p]; k++) begin
      t = port_list[p][k];
      cycles = 0;
      // Wait for this burst's AW and for the port 0 release
      while (aw_sent[p] <= k || (p == 0 && hold_w0)) begin
        @(posedge clk_i);
        #1;
        cycles++;
        if (cycles > TIMEOUT) timeout_fail("AW done or release of port 0 W beats");
      end
      for (int b = 0; b <= int'(tr_len[t]); b++) begin
        slv_w_valid_i[p] = 1'b1;
        slv_w_data_i[p]  = tr_seed[t] + data_t'(b);
        slv_w_strb_i[p]  = '1;
        slv_w_last_i[p]  = (b == int'(tr_len[t]));
        wait_slave_ready(p, 1'b1, "slave W ready");
      end
      slv_w_valid_i[p] = 1'b0;
      slv_w_last_i[p]  = 1'b0;
    end
  endtask

  task automatic drive_port(input int p);
    fork
      drive_aw(p);
      drive_w(p);
    join
  endtask

  // ------------------------------------------------------------------------
  // Master-side model, driven 1 ns after the edge
  // ------------------------------------------------------------------------
  always @(posedge clk_i) begin
    int t;
    #1;
    if (rst_n_i) begin
      mst_aw_ready_i = random_mode ? rand_bit() : 1'b1;
      mst_w_ready_i  = (aw_order.size() > 0) && (random_mode ? rand_bit() : 1'b1);
      for (int p = 0; p < NUM_PORTS; p++) begin
        slv_b_ready_i[p] = random_mode ? rand_bit() : 1'b1;
      end
      if (b_taken) begin
        mst_b_valid_i = 1'b0;
        b_taken = 1'b0;
      end
      if (!mst_b_valid_i && b_pending.size() > 0) begin
        t = b_pending[0];
        mst_b_valid_i = 1'b1;
        mst_b_id_i    = {tr_port[t], tr_id[t]};
        mst_b_resp_i  = tr_addr[t][1:0];
      end
    end
  end

  // Monitor and scoreboard, sampled mid-cycle where all signals are settled
  always @(negedge clk_i) begin
    int t;
    int p;
    if (rst_n_i) begin
      if (mst_aw_valid_o && mst_aw_ready_i) begin
        // Issuing port from the slave side handshake
        p = -1;
        for (int q = 0; q < NUM_PORTS; q++) begin
          if (slv_aw_valid_i[q] && slv_aw_ready_o[q]) p = q;
        end
        check_value("AW slave handshake", 64'(p >= 0), 64'd1);
        if (p < 0) p = int'(mst_aw_id_o[MST_ID_W-1 -: PORT_IDX_W]);
        check_value("AW port prefix", 64'(mst_aw_id_o[MST_ID_W-1 -: PORT_IDX_W]), 64'(p));
        check_value("AW count per port", 64'(aw_seen[p] < port_cnt[p]), 64'd1);
        t = port_list[p][aw_seen[p] % NUM_TRANS];
        aw_seen[p]++;
        check_value("AW slave ID", 64'(mst_aw_id_o[SLV_ID_W-1:0]), 64'(tr_id[t]));
        check_value("AW address", 64'(mst_aw_addr_o), 64'(tr_addr[t]));
        check_value("AW length", 64'(mst_aw_len_o), 64'(tr_len[t]));
        aw_order.push_back(t);
        check_value("AW beyond done W bursts", 64'(aw_order.size() <= MAX_W_TRANS), 64'd1);
        for (int q = 0; q < NUM_PORTS; q++) begin
          if (q == p) begin
            wait_grants[q] = 0;
          end else if (slv_aw_valid_i[q]) begin
            wait_grants[q]++;
            check_value("Grants while waiting", 64'(wait_grants[q] <= NUM_PORTS), 64'd1);
          end
        end
      end
      if (mst_w_valid_o && mst_w_ready_i) begin
        t = aw_order[0];
        check_value("W data", 64'(mst_w_data_o), 64'(tr_seed[t] + data_t'(beat)));
        check_value("W strobe", 64'(mst_w_strb_o), 64'hf);
        check_value("W last", 64'(mst_w_last_o), 64'(beat == int'(tr_len[t])));
        if (mst_w_last_o) begin
          void'(aw_order.pop_front());
          b_pending.push_back(t);
          beat = 0;
        end else begin
          beat++;
        end
      end
      if (mst_b_valid_i && mst_b_ready_o) begin
        void'(b_pending.pop_front());
        b_taken = 1'b1;
      end
      for (int q = 0; q < NUM_PORTS; q++) begin
        if (slv_b_valid_o[q] && slv_b_ready_i[q]) begin
          check_value("B count per port", 64'(b_seen[q] < port_cnt[q]), 64'd1);
          t = port_list[q][b_seen[q] % NUM_TRANS];
          b_seen[q]++;
          b_done++;
          check_value("B stripped ID", 64'(slv_b_id_o[q]), 64'(tr_id[t]));
          check_value("B response", 64'(slv_b_resp_o[q]), 64'(tr_addr[t][1:0]));
        end
      end
    end
  end

  // ------------------------------------------------------------------------
  // Test sequencing
  // ------------------------------------------------------------------------
  task automatic release_port0();
    int cycles;
    if (hold_w0) begin
      cycles = 0;
      while (aw_order.size() < MAX_W_TRANS) begin
        @(posedge clk_i);
        cycles++;
        if (cycles > TIMEOUT) timeout_fail("W order FIFO to fill");
      end
      repeat (20) @(posedge clk_i);
      check_value("AW held at FIFO depth", 64'(aw_order.size()), 64'(MAX_W_TRANS));
      #1;
      hold_w0 = 1'b0;
    end
  endtask

  task automatic run_test(input string name, input logic rnd, input logic hold);
    int err_start;
    int cycles;
    err_start = errors;
    random_mode = rnd;
    hold_w0 = hold;
    b_done = 0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      aw_seen[p] = 0;
      aw_sent[p] = 0;
      b_seen[p] = 0;
      wait_grants[p] = 0;
    end
    @(posedge clk_i);
    #1;
    fork
      drive_port(0);
      drive_port(1);
      drive_port(2);
      drive_port(3);
      release_port0();
    join
    cycles = 0;
    while (b_done < NUM_TRANS) begin
      @(posedge clk_i);
      cycles++;
      if (cycles > TIMEOUT) timeout_fail("all B responses");
    end
    check_value("Pending W bursts at end", 64'(aw_order.size()), 64'd0);
    $display("Test %s finished with %0d errors", name, errors - err_start);
  endtask

  initial begin
    errors = 0;
    beat = 0;
    b_taken = 1'b0;
    random_mode = 1'b0;
    hold_w0 = 1'b0;
    mst_aw_ready_i = 1'b0;
    mst_w_ready_i = 1'b0;
    mst_b_valid_i = 1'b0;
    mst_b_id_i = '0;
    mst_b_resp_i = '0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      slv_aw_valid_i[p] = 1'b0;
      slv_aw_id_i[p]    = '0;
      slv_aw_addr_i[p]  = '0;
      slv_aw_len_i[p]   = '0;
      slv_w_valid_i[p]  = 1'b0;
      slv_w_data_i[p]   = '0;
      slv_w_strb_i[p]   = '0;
      slv_w_last_i[p]   = 1'b0;
      slv_b_ready_i[p]  = 1'b0;
      port_cnt[p] = 0;
    end
    $readmemh("sim/axi_mux_stim.txt", stim_mem);
    for (int t = 0; t < NUM_TRANS; t++) begin
      tr_port[t] = port_idx_t'(stim_mem[t*5]);
      tr_id[t]   = slv_id_t'(stim_mem[t*5+1]);
      tr_addr[t] = stim_mem[t*5+2];
      tr_len[t]  = len_t'(stim_mem[t*5+3]);
      tr_seed[t] = stim_mem[t*5+4];
      port_list[tr_port[t]][port_cnt[tr_port[t]]] = t;
      port_cnt[tr_port[t]]++;
    end
    repeat (16) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    run_test("back_to_back", 1'b0, 1'b0);
    run_test("port0_w_hold", 1'b0, 1'b1);
    run_test("random_ready", 1'b1, 1'b0);
    $display("Checks done: %0d tests, %0d errors", 3, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule
